// ==== design/tmu_scan_macros.svh ====
// Width and size constants of the texture mapping scanline stage.
// Include this file in any unit that sizes coordinates, deltas or lanes.
`ifndef TMU_SCAN_MACROS_SVH
`define TMU_SCAN_MACROS_SVH

// signed screen and texture coordinates, 0 to 2047 in practice
`define TMU_COORD_W 12

// unsigned width of the absolute deltas, the divisor and the quotients
`define TMU_DELTA_W 11

// one divider lane per texture axis, lane 0 is U and lane 1 is V
`define TMU_NLANES 2

// a restoring divider retires one quotient bit per cycle
`define TMU_DIV_STEPS `TMU_DELTA_W

`endif

// ==== design/tmu_scan_pkg.sv ====
// Shared types of the scanline stage: the coordinate type and the FSM states.
// Units refer to these by scoped names, tmu_scan_pkg::coord_t and so on.
`include "tmu_scan_macros.svh"

package tmu_scan_pkg;

	// one coordinate as it travels through the stage, signed like the span inputs
	typedef logic signed [`TMU_COORD_W-1:0] coord_t;

	// divider lane sequencing
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0, // waiting for a span, ready for the next load
		DIV_RUN  = 2'd1, // shifting and subtracting, one quotient bit per cycle
		DIV_DONE = 2'd2  // quotient and remainder offered to the walker
	} div_state_e;

	// span walker sequencing
	typedef enum logic [1:0] {
		WALK_IDLE = 2'd0, // no span held
		WALK_WAIT = 2'd1, // span latched, quotients still being computed
		WALK_RUN  = 2'd2  // emitting one point per accepted cycle
	} walk_state_e;

endpackage

// ==== design/tmu_scan_if.sv ====
// Internal hand-offs of the scanline stage.
// tmu_span_if carries a set-up span to the lanes and the walker, with one ack
// formed at the top level. tmu_quot_if returns one lane's division result.
`timescale 1ns/1ps
`include "tmu_scan_macros.svh"

interface tmu_span_if;
	logic stb; // span register holds a valid span
	logic ack; // every lane and the walker are idle
	tmu_scan_pkg::coord_t y; // pass-through fields for the walker
	tmu_scan_pkg::coord_t s_x;
	tmu_scan_pkg::coord_t s_u;
	tmu_scan_pkg::coord_t s_v;
	tmu_scan_pkg::coord_t e_x;
	logic [`TMU_NLANES-1:0] sign; // high when the axis counts up along the span
	logic [`TMU_NLANES-1:0][`TMU_DELTA_W-1:0] delta; // absolute dividend per lane
	logic [`TMU_DELTA_W-1:0] divisor; // span length in pixels, never zero

	modport src (
		output stb, y, s_x, s_u, s_v, e_x, sign, delta, divisor,
		input  ack
	);

	modport snk (
		input stb, ack, y, s_x, s_u, s_v, e_x, sign, delta, divisor
	);
endinterface

interface tmu_quot_if;
	logic stb; // result valid, held until ack
	logic ack; // walker takes the result
	logic [`TMU_DELTA_W-1:0] quotient;
	logic [`TMU_DELTA_W-1:0] remainder;

	modport src (
		output stb, quotient, remainder,
		input  ack
	);

	modport snk (
		input  stb, quotient, remainder,
		output ack
	);
endinterface

// ==== design/tmu_scandivops.sv ====
// Setup register of the scanline stage. It accepts a raw span and one cycle
// later offers the pass-through fields, per-axis signs, absolute deltas and the
// common divisor. Two spans can overlap, as this register refills while the
// lanes and the walker work on the previous one.
`timescale 1ns/1ps
`include "tmu_scan_macros.svh"

module tmu_scandivops (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  tmu_scan_pkg::coord_t y0_i,
	input  tmu_scan_pkg::coord_t s_x0_i,
	input  tmu_scan_pkg::coord_t s_u0_i,
	input  tmu_scan_pkg::coord_t s_v0_i,
	input  tmu_scan_pkg::coord_t e_x0_i,
	input  tmu_scan_pkg::coord_t e_u0_i,
	input  tmu_scan_pkg::coord_t e_v0_i,
	tmu_span_if.src              span,
	output logic                 busy_o
);

	logic en; // register loads this cycle
	logic s1_valid_q; // register holds a span

	// coordinates are bounded to 0..2047 so the difference fits the delta width
	function automatic logic [`TMU_DELTA_W-1:0] abs_delta(input tmu_scan_pkg::coord_t s,
		input tmu_scan_pkg::coord_t e);
		tmu_scan_pkg::coord_t diff;
		diff = (e > s) ? (e - s) : (s - e);
		return diff[`TMU_DELTA_W-1:0];
	endfunction

	assign en = pipe_ack_o;
	assign pipe_ack_o = !s1_valid_q || span.ack; // empty, or the content leaves now

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_valid_q <= 1'b0;
		end else if (en) begin
			s1_valid_q <= pipe_stb_i; // a bubble goes in when no span is offered
		end
	end

	always_ff @(posedge sys_clk) begin
		if (en) begin
			span.y <= y0_i;
			span.s_x <= s_x0_i;
			span.s_u <= s_u0_i;
			span.s_v <= s_v0_i;
			span.e_x <= e_x0_i;
			span.sign[0] <= e_u0_i > s_u0_i; // equal endpoints step by zero either way
			span.sign[1] <= e_v0_i > s_v0_i;
			span.delta[0] <= abs_delta(s_u0_i, e_u0_i);
			span.delta[1] <= abs_delta(s_v0_i, e_v0_i);
			span.divisor <= (e_x0_i != s_x0_i) ? abs_delta(s_x0_i, e_x0_i)
				: `TMU_DELTA_W'(1); // one-pixel span divides by one
		end
	end

	assign span.stb = s1_valid_q;
	assign busy_o = s1_valid_q;

	// an offered span stays up with unchanged fields until this register takes it
	a_span_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_i && !pipe_ack_o |=> pipe_stb_i
		&& $stable({y0_i, s_x0_i, s_u0_i, s_v0_i, e_x0_i, e_u0_i, e_v0_i}));

	// spans run left to right and every coordinate is non-negative
	a_span_pre: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_i && pipe_ack_o |-> e_x0_i >= s_x0_i
		&& !y0_i[`TMU_COORD_W-1] && !s_x0_i[`TMU_COORD_W-1] && !e_x0_i[`TMU_COORD_W-1]
		&& !s_u0_i[`TMU_COORD_W-1] && !e_u0_i[`TMU_COORD_W-1]
		&& !s_v0_i[`TMU_COORD_W-1] && !e_v0_i[`TMU_COORD_W-1]);

endmodule

// ==== design/tmu_scandiv_lane.sv ====
// One sequential divider lane. It loads its delta and the common divisor when a
// span is accepted, runs a restoring shift-subtract loop for one cycle per
// quotient bit and holds quotient and remainder until the walker acks.
// Instantiate once per texture axis with LANE selecting the dividend.
`timescale 1ns/1ps
`include "tmu_scan_macros.svh"

module tmu_scandiv_lane #(
	parameter int unsigned LANE = 0
) (
	input  logic    sys_clk,
	input  logic    sys_rst,
	tmu_span_if.snk span,
	output logic    ready_o,
	tmu_quot_if.src quot,
	output logic    busy_o
);

	localparam int unsigned STEPS = `TMU_DIV_STEPS;
	localparam int unsigned CNT_W = $clog2(STEPS);

	tmu_scan_pkg::div_state_e state_q;
	logic [CNT_W-1:0] step_q; // quotient bits retired so far
	logic [`TMU_DELTA_W-1:0] quo_q; // dividend shifts out the top, quotient in the bottom
	logic [`TMU_DELTA_W-1:0] rem_q; // partial remainder, always below the divisor
	logic [`TMU_DELTA_W-1:0] div_q;
	logic [`TMU_DELTA_W:0] trial; // partial remainder with the next dividend bit
	logic [`TMU_DELTA_W:0] diff;
	logic fits; // divisor goes into the trial value
	logic load;

	assign load = span.stb && span.ack; // ack already implies this lane is idle
	assign trial = {rem_q, quo_q[`TMU_DELTA_W-1]};
	assign diff = trial - {1'b0, div_q};
	assign fits = trial >= {1'b0, div_q};

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= tmu_scan_pkg::DIV_IDLE;
			step_q <= '0;
		end else begin
			unique case (state_q)
				tmu_scan_pkg::DIV_IDLE: begin
					if (load) begin
						state_q <= tmu_scan_pkg::DIV_RUN;
						step_q <= '0;
					end
				end
				tmu_scan_pkg::DIV_RUN: begin
					step_q <= step_q + 1'b1;
					if (step_q == CNT_W'(STEPS - 1))
						state_q <= tmu_scan_pkg::DIV_DONE; // last bit retires this cycle
				end
				tmu_scan_pkg::DIV_DONE: begin
					if (quot.ack)
						state_q <= tmu_scan_pkg::DIV_IDLE;
				end
				default: state_q <= tmu_scan_pkg::DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			quo_q <= span.delta[LANE];
			rem_q <= '0;
			div_q <= span.divisor;
		end else if (state_q == tmu_scan_pkg::DIV_RUN) begin
			if (fits) begin
				rem_q <= diff[`TMU_DELTA_W-1:0]; // result stays below the divisor
				quo_q <= {quo_q[`TMU_DELTA_W-2:0], 1'b1};
			end else begin
				rem_q <= trial[`TMU_DELTA_W-1:0]; // restore, the top bit is zero here
				quo_q <= {quo_q[`TMU_DELTA_W-2:0], 1'b0};
			end
		end
	end

	assign quot.stb = state_q == tmu_scan_pkg::DIV_DONE;
	assign quot.quotient = quo_q;
	assign quot.remainder = rem_q;
	assign ready_o = state_q == tmu_scan_pkg::DIV_IDLE;
	assign busy_o = state_q != tmu_scan_pkg::DIV_IDLE;

	// the walker's error wrap relies on a proper remainder
	a_rem_lt_div: assert property (@(posedge sys_clk) disable iff (sys_rst)
		quot.stb |-> quot.remainder < div_q);

endmodule

// ==== design/tmu_scanwalk.sv ====
// Span walker. It latches a span on the accept cycle, waits until every lane
// offers its quotient, then emits one point per accepted output cycle from S_X
// to E_X. Each axis steps by its quotient and one extra unit whenever the
// accumulated remainder reaches the divisor, which gives the floor rule.
`timescale 1ns/1ps
`include "tmu_scan_macros.svh"

module tmu_scanwalk (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	tmu_span_if.snk              span,
	output logic                 ready_o,
	tmu_quot_if.snk              quot [`TMU_NLANES],
	output logic                 pipe_stb_o,
	input  logic                 pipe_ack_i,
	output tmu_scan_pkg::coord_t x_o,
	output tmu_scan_pkg::coord_t y_o,
	output tmu_scan_pkg::coord_t u_o,
	output tmu_scan_pkg::coord_t v_o,
	output logic                 last_o,
	output logic                 busy_o
);

	tmu_scan_pkg::walk_state_e state_q;
	tmu_scan_pkg::coord_t x_q, y_q, e_x_q;
	tmu_scan_pkg::coord_t pos_q [`TMU_NLANES]; // current U and V
	tmu_scan_pkg::coord_t pos_nxt [`TMU_NLANES];
	logic [`TMU_NLANES-1:0] sign_q;
	logic [`TMU_DELTA_W-1:0] div_q;
	logic [`TMU_NLANES-1:0][`TMU_DELTA_W-1:0] quo_q, rem_q, err_q, err_nxt;
	logic [`TMU_NLANES-1:0][`TMU_DELTA_W-1:0] lane_quo, lane_rem;
	logic [`TMU_NLANES-1:0] lane_stb;
	logic all_ack; // every lane result taken this cycle
	logic fire; // current point accepted downstream

	// interface arrays need constant indices, so flatten the lane results here
	for (genvar i = 0; i < `TMU_NLANES; i++) begin : g_lane
		assign lane_stb[i] = quot[i].stb;
		assign lane_quo[i] = quot[i].quotient;
		assign lane_rem[i] = quot[i].remainder;
		assign quot[i].ack = all_ack; // all lanes are released together
	end

	assign all_ack = (state_q == tmu_scan_pkg::WALK_WAIT) && (&lane_stb);
	assign pipe_stb_o = state_q == tmu_scan_pkg::WALK_RUN;
	assign fire = pipe_stb_o && pipe_ack_i;
	assign last_o = x_q == e_x_q;

	always_comb begin
		logic [`TMU_DELTA_W:0] sum;
		tmu_scan_pkg::coord_t step;
		for (int i = 0; i < `TMU_NLANES; i++) begin
			sum = {1'b0, err_q[i]} + {1'b0, rem_q[i]}; // below twice the divisor
			step = tmu_scan_pkg::coord_t'({1'b0, quo_q[i]});
			err_nxt[i] = sum[`TMU_DELTA_W-1:0];
			if (sum >= {1'b0, div_q}) begin
				err_nxt[i] = sum[`TMU_DELTA_W-1:0] - div_q; // wrap and carry one unit
				step = step + 1'b1;
			end
			pos_nxt[i] = sign_q[i] ? pos_q[i] + step : pos_q[i] - step;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= tmu_scan_pkg::WALK_IDLE;
		end else begin
			unique case (state_q)
				tmu_scan_pkg::WALK_IDLE: if (span.stb && span.ack) state_q <= tmu_scan_pkg::WALK_WAIT;
				tmu_scan_pkg::WALK_WAIT: if (all_ack) state_q <= tmu_scan_pkg::WALK_RUN;
				tmu_scan_pkg::WALK_RUN: if (fire && last_o) state_q <= tmu_scan_pkg::WALK_IDLE;
				default: state_q <= tmu_scan_pkg::WALK_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state_q == tmu_scan_pkg::WALK_IDLE && span.stb && span.ack) begin
			x_q <= span.s_x; // first point sits at the start endpoint
			y_q <= span.y;
			e_x_q <= span.e_x;
			pos_q[0] <= span.s_u;
			pos_q[1] <= span.s_v;
			sign_q <= span.sign;
			div_q <= span.divisor;
		end else if (all_ack) begin
			quo_q <= lane_quo;
			rem_q <= lane_rem;
			err_q <= '0;
		end else if (fire && !last_o) begin
			x_q <= x_q + 1'b1;
			err_q <= err_nxt;
			for (int i = 0; i < `TMU_NLANES; i++)
				pos_q[i] <= pos_nxt[i];
		end
	end

	assign x_o = x_q;
	assign y_o = y_q;
	assign u_o = pos_q[0];
	assign v_o = pos_q[1];
	assign ready_o = state_q == tmu_scan_pkg::WALK_IDLE;
	assign busy_o = state_q != tmu_scan_pkg::WALK_IDLE;

	// the walk stops on the end point, so X never overshoots it
	a_x_in_span: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> x_o <= e_x_q);

endmodule

// ==== design/tmu_scanline.sv ====
// Scanline stage of the texture mapping unit. A span with row Y and two
// endpoints goes in through the stb/ack handshake, and textured points with
// X, Y, U and V come out one per accepted cycle, last_o marking the end point.
// Setup register, divider lanes and walker are wired through interfaces here.
`timescale 1ns/1ps
`include "tmu_scan_macros.svh"

module tmu_scanline (
	input  logic                 sys_clk,
	input  logic                 sys_rst,
	input  logic                 pipe_stb_i,
	output logic                 pipe_ack_o,
	input  tmu_scan_pkg::coord_t y0_i,
	input  tmu_scan_pkg::coord_t s_x0_i,
	input  tmu_scan_pkg::coord_t s_u0_i,
	input  tmu_scan_pkg::coord_t s_v0_i,
	input  tmu_scan_pkg::coord_t e_x0_i,
	input  tmu_scan_pkg::coord_t e_u0_i,
	input  tmu_scan_pkg::coord_t e_v0_i,
	output logic                 pipe_stb_o,
	input  logic                 pipe_ack_i,
	output tmu_scan_pkg::coord_t x_o,
	output tmu_scan_pkg::coord_t y_o,
	output tmu_scan_pkg::coord_t u_o,
	output tmu_scan_pkg::coord_t v_o,
	output logic                 last_o,
	output logic                 busy_o
);

	tmu_span_if span_if ();
	tmu_quot_if quot_if [`TMU_NLANES] ();

	logic divops_busy;
	logic walk_busy;
	logic walk_ready;
	logic [`TMU_NLANES-1:0] lane_ready;
	logic [`TMU_NLANES-1:0] lane_busy;

	// a span moves on only when every consumer is idle, so all load together
	assign span_if.ack = (&lane_ready) && walk_ready;

	tmu_scandivops i_divops (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (pipe_stb_i),
		.pipe_ack_o (pipe_ack_o),
		.y0_i       (y0_i),
		.s_x0_i     (s_x0_i),
		.s_u0_i     (s_u0_i),
		.s_v0_i     (s_v0_i),
		.e_x0_i     (e_x0_i),
		.e_u0_i     (e_u0_i),
		.e_v0_i     (e_v0_i),
		.span       (span_if),
		.busy_o     (divops_busy)
	);

	for (genvar i = 0; i < `TMU_NLANES; i++) begin : g_div
		tmu_scandiv_lane #(
			.LANE (i)
		) i_lane (
			.sys_clk (sys_clk),
			.sys_rst (sys_rst),
			.span    (span_if),
			.ready_o (lane_ready[i]),
			.quot    (quot_if[i]),
			.busy_o  (lane_busy[i])
		);
	end

	tmu_scanwalk i_walk (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.span       (span_if),
		.ready_o    (walk_ready),
		.quot       (quot_if),
		.pipe_stb_o (pipe_stb_o),
		.pipe_ack_i (pipe_ack_i),
		.x_o        (x_o),
		.y_o        (y_o),
		.u_o        (u_o),
		.v_o        (v_o),
		.last_o     (last_o),
		.busy_o     (walk_busy)
	);

	assign busy_o = divops_busy || (|lane_busy) || walk_busy; // any span still in flight

endmodule

// ==== verif/tb_tmu_scanline.sv ====
// Self-checking testbench of the texture mapping scanline stage.
// Random spans with gaps go in and random back-pressure is applied at the output.
// Every emitted point is compared with a floor-interpolation model of the span.
`timescale 1ns/1ps

module tb_tmu_scanline;

	localparam int NSPANS = 40;
	localparam int TIMEOUT_CYCLES = NSPANS * (64 * 4 + 40); // worst span length plus overhead

	logic sys_clk;
	logic sys_rst;
	logic pipe_stb_i;
	logic pipe_ack_o;
	tmu_scan_pkg::coord_t y0_i, s_x0_i, s_u0_i, s_v0_i, e_x0_i, e_u0_i, e_v0_i;
	logic pipe_stb_o;
	logic pipe_ack_i;
	tmu_scan_pkg::coord_t x_o, y_o, u_o, v_o;
	logic last_o;
	logic busy_o;

	integer seed; // shared by every $random call of the stimulus
	int cycles; // clock edges since time zero
	int sent; // spans accepted by the DUT
	int pushed; // points queued by the model
	int checked; // points compared so far
	logic took; // span handshake seen on the last edge

	tmu_scan_pkg::coord_t exp_x[$], exp_y[$], exp_u[$], exp_v[$]; // expected points in order
	bit exp_last[$];

	logic prev_stall; // point offered but not taken on the previous edge
	tmu_scan_pkg::coord_t prev_x, prev_y, prev_u, prev_v;
	logic prev_last;

	tmu_scanline i_dut (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.pipe_stb_i (pipe_stb_i),
		.pipe_ack_o (pipe_ack_o),
		.y0_i       (y0_i),
		.s_x0_i     (s_x0_i),
		.s_u0_i     (s_u0_i),
		.s_v0_i     (s_v0_i),
		.e_x0_i     (e_x0_i),
		.e_u0_i     (e_u0_i),
		.e_v0_i     (e_v0_i),
		.pipe_stb_o (pipe_stb_o),
		.pipe_ack_i (pipe_ack_i),
		.x_o        (x_o),
		.y_o        (y_o),
		.u_o        (u_o),
		.v_o        (v_o),
		.last_o     (last_o),
		.busy_o     (busy_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk; // 4 ns period
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d points seen", cycles, checked, pushed);
			$display("TEST FAILED");
			$fatal(1, "simulation did not complete");
		end
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// texture coordinate at step k of n, the offset rounded toward the start value
	function automatic tmu_scan_pkg::coord_t lerp_floor(input int s, input int e, input int k,
		input int n);
		int off;
		if (n == 0)
			return tmu_scan_pkg::coord_t'(s); // one-pixel span keeps the start value
		off = (k * ((e > s) ? e - s : s - e)) / n;
		return (e >= s) ? tmu_scan_pkg::coord_t'(s + off) : tmu_scan_pkg::coord_t'(s - off);
	endfunction

	task automatic check_coord(input string name, input tmu_scan_pkg::coord_t got,
		input tmu_scan_pkg::coord_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "coordinate mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0b, expected %0b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "flag mismatch on %s", name);
		end
	endtask

	// expands the span on the DUT inputs into one expected point per pixel
	task automatic push_span_points();
		int n;
		n = int'(e_x0_i) - int'(s_x0_i);
		for (int k = 0; k <= n; k++) begin
			exp_x.push_back(tmu_scan_pkg::coord_t'(int'(s_x0_i) + k));
			exp_y.push_back(y0_i);
			exp_u.push_back(lerp_floor(int'(s_u0_i), int'(e_u0_i), k, n));
			exp_v.push_back(lerp_floor(int'(s_v0_i), int'(e_v0_i), k, n));
			exp_last.push_back(k == n);
			pushed++;
		end
	endtask

	task automatic drive_span(input int idx);
		int len;
		len = rand_below(64);
		if (idx == 0)
			len = 0; // single point span
		if (idx == 2)
			len = 63; // longest span, stepping down over the full range
		s_x0_i = tmu_scan_pkg::coord_t'(rand_below(64));
		e_x0_i = tmu_scan_pkg::coord_t'(int'(s_x0_i) + len);
		y0_i = tmu_scan_pkg::coord_t'(rand_below(2048));
		s_u0_i = tmu_scan_pkg::coord_t'(rand_below(2048));
		e_u0_i = tmu_scan_pkg::coord_t'(rand_below(2048));
		s_v0_i = tmu_scan_pkg::coord_t'(rand_below(2048));
		e_v0_i = tmu_scan_pkg::coord_t'(rand_below(2048));
		if (idx == 1) begin
			e_u0_i = s_u0_i; // flat texture along the span
			e_v0_i = s_v0_i;
		end
		if (idx == 2) begin
			s_u0_i = 12'sd2047;
			e_u0_i = 12'sd0;
		end
		pipe_stb_i = 1'b1;
	endtask

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			prev_stall = 1'b0;
		end else begin
			if (pipe_stb_i && pipe_ack_o)
				push_span_points(); // span taken on this edge
			if (!busy_o)
				check_flag("pipe_ack_o", pipe_ack_o, 1'b1); // an idle stage takes a span at once
			if (prev_stall) begin // a stalled point stays on the outputs unchanged
				check_flag("pipe_stb_o", pipe_stb_o, 1'b1);
				check_coord("x_o", x_o, prev_x);
				check_coord("y_o", y_o, prev_y);
				check_coord("u_o", u_o, prev_u);
				check_coord("v_o", v_o, prev_v);
				check_flag("last_o", last_o, prev_last);
			end
			if (pipe_stb_o && pipe_ack_i) begin
				if (exp_x.size() == 0) begin
					$display("point at x %0d was emitted with no span outstanding", x_o);
					$display("TEST FAILED");
					$fatal(1, "extra output point");
				end
				check_coord("x_o", x_o, exp_x.pop_front());
				check_coord("y_o", y_o, exp_y.pop_front());
				check_coord("u_o", u_o, exp_u.pop_front());
				check_coord("v_o", v_o, exp_v.pop_front());
				check_flag("last_o", last_o, exp_last.pop_front());
				checked++;
			end
			prev_stall = pipe_stb_o && !pipe_ack_i;
			prev_x = x_o;
			prev_y = y_o;
			prev_u = u_o;
			prev_v = v_o;
			prev_last = last_o;
		end
	end

	initial begin
		seed = 32'h6ee8;
		cycles = 0;
		sent = 0;
		pushed = 0;
		checked = 0;
		sys_rst = 1'b1;
		pipe_stb_i = 1'b0;
		pipe_ack_i = 1'b0;
		y0_i = '0;
		s_x0_i = '0;
		s_u0_i = '0;
		s_v0_i = '0;
		e_x0_i = '0;
		e_u0_i = '0;
		e_v0_i = '0;
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		check_flag("pipe_stb_o", pipe_stb_o, 1'b0); // nothing in flight after reset
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("pipe_ack_o", pipe_ack_o, 1'b1);

		while (sent < NSPANS) begin
			@(posedge sys_clk);
			took = pipe_stb_i && pipe_ack_o;
			#1;
			if (took)
				sent++;
			pipe_ack_i = rand_below(4) != 0; // output takes a point on 3 cycles of 4
			if (took || !pipe_stb_i) begin // an offered span is held until taken
				if (sent < NSPANS && rand_below(4) != 0)
					drive_span(sent);
				else
					pipe_stb_i = 1'b0; // gap between spans
			end
		end

		while (exp_x.size() != 0) begin // the last expected point leaves the DUT
			@(posedge sys_clk);
			#1;
			pipe_ack_i = rand_below(4) != 0;
		end

		check_flag("pipe_stb_o", pipe_stb_o, 1'b0); // the final point emptied every stage
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("pipe_ack_o", pipe_ack_o, 1'b1);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tmu_scanline.f ====
+incdir+design
design/tmu_scan_pkg.sv
design/tmu_scan_if.sv
design/tmu_scandivops.sv
design/tmu_scandiv_lane.sv
design/tmu_scanwalk.sv
design/tmu_scanline.sv
verif/tb_tmu_scanline.sv

// ==== Makefile ====
TB = tb_tmu_scanline

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f tmu_scanline.f --top-module $(TB)

run: build
	./obj_dir/V$(TB) | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f tmu_scanline.f --top-module tmu_scanline

clean:
	rm -rf obj_dir sim.log
